//--- Makefile
TOOL  = verilator
FLAGS = --timing
TOP   = tb_gpu_registers
FLIST = tb.f
OBJ   = obj_dir
LOG   = sim.log
PASS  = All checks passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)

//--- design/gpu_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_reg_bank
(
	input  wire                     S_AXI_ACLK,
	input  wire                     S_AXI_ARESETN,
	reg_write_if.wr_dst             wr,
	output gpu_reg_pkg::ctrl_bank_t o_ctrl
);

	localparam int SEL_W = gpu_reg_pkg::IDX_W - 1;

	gpu_reg_pkg::data_t ctrl_q [gpu_reg_pkg::NUM_CTRL];
	logic [SEL_W-1:0]   word_sel;

	assign word_sel = wr.wr_idx[SEL_W-1:0];   // msb is always clear here

	// ------------------------------------------------
	// byte lane update
	// ------------------------------------------------
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int i = 0; i < gpu_reg_pkg::NUM_CTRL; i++)
				ctrl_q[i] <= '0;
		end
		else if (wr.wr_en)
		begin
			for (int b = 0; b < gpu_reg_pkg::STRB_W; b++)
			begin
				if (wr.wr_strb[b])
					ctrl_q[word_sel][b*8 +: 8] <= wr.wr_data[b*8 +: 8];
			end
		end
	end

	// flatten for the bank output
	always_comb
	begin
		for (int i = 0; i < gpu_reg_pkg::NUM_CTRL; i++)
			o_ctrl[i*gpu_reg_pkg::DATA_W +: gpu_reg_pkg::DATA_W] = ctrl_q[i];
	end

endmodule

`default_nettype wire

//--- design/gpu_reg_pkg.sv
`default_nettype none

package gpu_reg_pkg;

	// ------------------------------------------------
	// bus and map geometry
	// ------------------------------------------------
	localparam int DATA_W     = 32;
	localparam int STRB_W     = DATA_W / 8;
	localparam int NUM_CTRL   = 16;
	localparam int NUM_STAT   = 16;
	localparam int IDX_W      = 5;    // 32-word map
	localparam int IDX_LSB    = 2;    // word aligned
	localparam int DEF_ADDR_W = 32;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [IDX_W-1:0]  idx_t;   // msb set selects the status half
	typedef logic [1:0]        resp_t;

	localparam resp_t RESP_OKAY = 2'b00;

	// word i lives at bits [i*DATA_W +: DATA_W]
	typedef logic [NUM_CTRL*DATA_W-1:0] ctrl_bank_t;
	typedef logic [NUM_STAT*DATA_W-1:0] stat_bank_t;

	// ------------------------------------------------
	// channel FSM states
	// ------------------------------------------------
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ACCEPT,
		WR_RESP
	} wr_state_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ACCEPT,
		RD_DATA
	} rd_state_t;

endpackage

`default_nettype wire

//--- design/gpu_reg_read_channel.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_reg_read_channel #(
	parameter int ADDR_W = gpu_reg_pkg::DEF_ADDR_W
)
(
	input  wire                         S_AXI_ACLK,
	input  wire                         S_AXI_ARESETN,
	input  wire [ADDR_W-1:0]            i_araddr,
	input  wire                         i_arvalid,
	output logic                        o_arready,
	output gpu_reg_pkg::data_t          o_rdata,
	output gpu_reg_pkg::resp_t          o_rresp,
	output logic                        o_rvalid,
	input  wire                         i_rready,
	input  wire gpu_reg_pkg::ctrl_bank_t i_ctrl,
	input  wire gpu_reg_pkg::stat_bank_t i_stat
);

	localparam int SEL_W = gpu_reg_pkg::IDX_W - 1;

	gpu_reg_pkg::rd_state_t state_q;
	gpu_reg_pkg::rd_state_t state_d;
	gpu_reg_pkg::idx_t      ar_idx_q;
	gpu_reg_pkg::data_t     rd_word;
	logic [SEL_W-1:0]       word_sel;

	// ------------------------------------------------
	// AR/R sequence
	// ------------------------------------------------
	// no new AR until the R beat has gone out
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			gpu_reg_pkg::RD_IDLE:
			begin
				if (i_arvalid)
					state_d = gpu_reg_pkg::RD_ACCEPT;
			end
			gpu_reg_pkg::RD_ACCEPT:
				state_d = gpu_reg_pkg::RD_DATA;
			gpu_reg_pkg::RD_DATA:
			begin
				if (i_rready)
					state_d = gpu_reg_pkg::RD_IDLE;
			end
			default:
				state_d = gpu_reg_pkg::RD_IDLE;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			state_q <= gpu_reg_pkg::RD_IDLE;
		else
			state_q <= state_d;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (state_q == gpu_reg_pkg::RD_IDLE && i_arvalid)
			ar_idx_q <= i_araddr[gpu_reg_pkg::IDX_LSB +: gpu_reg_pkg::IDX_W];
	end

	// ------------------------------------------------
	// read mux, msb picks the status half
	// ------------------------------------------------
	assign word_sel = ar_idx_q[SEL_W-1:0];

	always_comb
	begin
		if (ar_idx_q[gpu_reg_pkg::IDX_W-1])
			rd_word = i_stat[word_sel*gpu_reg_pkg::DATA_W +: gpu_reg_pkg::DATA_W];
		else
			rd_word = i_ctrl[word_sel*gpu_reg_pkg::DATA_W +: gpu_reg_pkg::DATA_W];
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rdata <= '0;
		else if (state_q == gpu_reg_pkg::RD_ACCEPT)
			o_rdata <= rd_word;   // stays put while rvalid waits
	end

	assign o_arready = (state_q == gpu_reg_pkg::RD_ACCEPT);
	assign o_rvalid  = (state_q == gpu_reg_pkg::RD_DATA);
	assign o_rresp   = gpu_reg_pkg::RESP_OKAY;

endmodule

`default_nettype wire

//--- design/gpu_reg_write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_reg_write_channel #(
	parameter int ADDR_W = gpu_reg_pkg::DEF_ADDR_W
)
(
	input  wire                     S_AXI_ACLK,
	input  wire                     S_AXI_ARESETN,
	input  wire [ADDR_W-1:0]        i_awaddr,
	input  wire                     i_awvalid,
	output logic                    o_awready,
	input  wire gpu_reg_pkg::data_t i_wdata,
	input  wire gpu_reg_pkg::strb_t i_wstrb,
	input  wire                     i_wvalid,
	output logic                    o_wready,
	output gpu_reg_pkg::resp_t      o_bresp,
	output logic                    o_bvalid,
	input  wire                     i_bready,
	reg_write_if.wr_src             wr
);

	gpu_reg_pkg::wr_state_t state_q;
	gpu_reg_pkg::wr_state_t state_d;
	gpu_reg_pkg::idx_t      aw_idx;
	gpu_reg_pkg::idx_t      idx_q;
	gpu_reg_pkg::data_t     data_q;
	gpu_reg_pkg::strb_t     strb_q;
	logic                   req;
	logic                   accept;

	assign aw_idx = i_awaddr[gpu_reg_pkg::IDX_LSB +: gpu_reg_pkg::IDX_W];
	assign req    = i_awvalid && i_wvalid;   // address and data together
	assign accept = (state_q == gpu_reg_pkg::WR_ACCEPT);

	// ------------------------------------------------
	// AW/W/B sequence
	// ------------------------------------------------
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			gpu_reg_pkg::WR_IDLE:
			begin
				if (req)
					state_d = gpu_reg_pkg::WR_ACCEPT;
			end
			gpu_reg_pkg::WR_ACCEPT:
			begin
				state_d = gpu_reg_pkg::WR_RESP;   // both handshakes close here
			end
			gpu_reg_pkg::WR_RESP:
			begin
				if (i_bready)
					state_d = gpu_reg_pkg::WR_IDLE;
			end
			default:
			begin
				state_d = gpu_reg_pkg::WR_IDLE;
			end
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			state_q <= gpu_reg_pkg::WR_IDLE;
		else
			state_q <= state_d;
	end

	// master holds the payload stable until the handshake
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (state_q == gpu_reg_pkg::WR_IDLE && req)
		begin
			idx_q  <= aw_idx;
			data_q <= i_wdata;
			strb_q <= i_wstrb;
		end
	end

	assign o_awready = accept;
	assign o_wready  = accept;
	assign o_bvalid  = (state_q == gpu_reg_pkg::WR_RESP);
	assign o_bresp   = gpu_reg_pkg::RESP_OKAY;

	// ------------------------------------------------
	// decoded write toward the bank
	// ------------------------------------------------
	// status half is read only, so it never pulses
	assign wr.wr_en   = accept && !idx_q[gpu_reg_pkg::IDX_W-1];
	assign wr.wr_idx  = idx_q;
	assign wr.wr_data = data_q;
	assign wr.wr_strb = strb_q;

endmodule

`default_nettype wire

//--- design/gpu_registers.sv
`timescale 1ns/1ps
`default_nettype none

module gpu_registers #(
	parameter int ADDR_W = gpu_reg_pkg::DEF_ADDR_W
)
(
	input  wire                          S_AXI_ACLK,
	input  wire                          S_AXI_ARESETN,

	// write address / data / response
	input  wire [ADDR_W-1:0]             S_AXI_AWADDR,
	input  wire                          S_AXI_AWVALID,
	output logic                         S_AXI_AWREADY,
	input  wire gpu_reg_pkg::data_t      S_AXI_WDATA,
	input  wire gpu_reg_pkg::strb_t      S_AXI_WSTRB,
	input  wire                          S_AXI_WVALID,
	output logic                         S_AXI_WREADY,
	output gpu_reg_pkg::resp_t           S_AXI_BRESP,
	output logic                         S_AXI_BVALID,
	input  wire                          S_AXI_BREADY,

	// read address / data
	input  wire [ADDR_W-1:0]             S_AXI_ARADDR,
	input  wire                          S_AXI_ARVALID,
	output logic                         S_AXI_ARREADY,
	output gpu_reg_pkg::data_t           S_AXI_RDATA,
	output gpu_reg_pkg::resp_t           S_AXI_RRESP,
	output logic                         S_AXI_RVALID,
	input  wire                          S_AXI_RREADY,

	// register banks
	output gpu_reg_pkg::ctrl_bank_t      o_ctrl_regs,
	input  wire gpu_reg_pkg::stat_bank_t i_stat_regs
);

	gpu_reg_pkg::ctrl_bank_t ctrl_bank;

	reg_write_if wr_bus ();

	assign o_ctrl_regs = ctrl_bank;   // same word also feeds read-back

	// ------------------------------------------------
	// write side
	// ------------------------------------------------
	gpu_reg_write_channel #(
		.ADDR_W (ADDR_W)
	) u_write_channel
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awaddr      (S_AXI_AWADDR),
		.i_awvalid     (S_AXI_AWVALID),
		.o_awready     (S_AXI_AWREADY),
		.i_wdata       (S_AXI_WDATA),
		.i_wstrb       (S_AXI_WSTRB),
		.i_wvalid      (S_AXI_WVALID),
		.o_wready      (S_AXI_WREADY),
		.o_bresp       (S_AXI_BRESP),
		.o_bvalid      (S_AXI_BVALID),
		.i_bready      (S_AXI_BREADY),
		.wr            (wr_bus.wr_src)
	);

	gpu_reg_bank u_bank
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr            (wr_bus.wr_dst),
		.o_ctrl        (ctrl_bank)
	);

	// ------------------------------------------------
	// read side
	// ------------------------------------------------
	gpu_reg_read_channel #(
		.ADDR_W (ADDR_W)
	) u_read_channel
	(
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_araddr      (S_AXI_ARADDR),
		.i_arvalid     (S_AXI_ARVALID),
		.o_arready     (S_AXI_ARREADY),
		.o_rdata       (S_AXI_RDATA),
		.o_rresp       (S_AXI_RRESP),
		.o_rvalid      (S_AXI_RVALID),
		.i_rready      (S_AXI_RREADY),
		.i_ctrl        (ctrl_bank),
		.i_stat        (i_stat_regs)
	);

endmodule

`default_nettype wire

//--- design/reg_write_if.sv
`timescale 1ns/1ps
`default_nettype none

// one decoded write, taken by the bank in the cycle of the pulse
interface reg_write_if;
	logic               wr_en;     // single cycle, control indices only
	gpu_reg_pkg::idx_t  wr_idx;
	gpu_reg_pkg::data_t wr_data;
	gpu_reg_pkg::strb_t wr_strb;

	modport wr_src
	(
		output wr_en,
		output wr_idx,
		output wr_data,
		output wr_strb
	);

	modport wr_dst
	(
		input wr_en,
		input wr_idx,
		input wr_data,
		input wr_strb
	);
endinterface

`default_nettype wire

//--- sim/tb_axi_tasks.svh
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// --------------------------------------------------
// write side, AW and W raised together
// --------------------------------------------------
task automatic raise_write(input addr_t addr, input gpu_reg_pkg::data_t data,
	input gpu_reg_pkg::strb_t strb);
	S_AXI_AWADDR  = addr;
	S_AXI_WDATA   = data;
	S_AXI_WSTRB   = strb;
	S_AXI_AWVALID = 1'b1;
	S_AXI_WVALID  = 1'b1;
endtask

// counts falling edges up to the one after the transfer edge
task automatic wait_write_accept(output int cycles);
	cycles = 0;
	while (!(S_AXI_AWREADY && S_AXI_WREADY))
	begin
		@(negedge S_AXI_ACLK);
		cycles++;
		if (cycles > TIMEOUT)
			fail_run("timeout waiting for AWREADY and WREADY");
	end
	@(negedge S_AXI_ACLK);
	cycles++;
	S_AXI_AWVALID = 1'b0;
	S_AXI_WVALID  = 1'b0;
endtask

task automatic wait_bvalid(output int cycles);
	cycles = 0;
	while (!S_AXI_BVALID)
	begin
		@(negedge S_AXI_ACLK);
		cycles++;
		if (cycles > TIMEOUT)
			fail_run("timeout waiting for BVALID");
	end
endtask

// BREADY low for hold cycles, then one handshake
task automatic finish_b(input int hold, output gpu_reg_pkg::resp_t resp);
	repeat (hold)
	begin
		@(negedge S_AXI_ACLK);
		check_flag("S_AXI_BVALID", S_AXI_BVALID, 1'b1);
		check_flag("S_AXI_AWREADY", S_AXI_AWREADY, 1'b0);   // no AW while B waits
		check_flag("S_AXI_WREADY", S_AXI_WREADY, 1'b0);
	end
	S_AXI_BREADY = 1'b1;
	resp = S_AXI_BRESP;
	@(negedge S_AXI_ACLK);
	S_AXI_BREADY = 1'b0;
endtask

// --------------------------------------------------
// read side
// --------------------------------------------------
task automatic raise_read(input addr_t addr);
	S_AXI_ARADDR  = addr;
	S_AXI_ARVALID = 1'b1;
endtask

task automatic wait_read_accept(output int cycles);
	cycles = 0;
	while (!S_AXI_ARREADY)
	begin
		@(negedge S_AXI_ACLK);
		cycles++;
		if (cycles > TIMEOUT)
			fail_run("timeout waiting for ARREADY");
	end
	@(negedge S_AXI_ACLK);
	cycles++;
	S_AXI_ARVALID = 1'b0;
endtask

task automatic wait_rvalid(output int cycles);
	cycles = 0;
	while (!S_AXI_RVALID)
	begin
		@(negedge S_AXI_ACLK);
		cycles++;
		if (cycles > TIMEOUT)
			fail_run("timeout waiting for RVALID");
	end
endtask

task automatic finish_r(input int hold, output gpu_reg_pkg::data_t data,
	output gpu_reg_pkg::resp_t resp);
	gpu_reg_pkg::data_t first;
	first = S_AXI_RDATA;
	repeat (hold)
	begin
		@(negedge S_AXI_ACLK);
		check_flag("S_AXI_RVALID", S_AXI_RVALID, 1'b1);
		check_flag("S_AXI_ARREADY", S_AXI_ARREADY, 1'b0);
		check_data("S_AXI_RDATA", S_AXI_RDATA, first);   // held stable
	end
	S_AXI_RREADY = 1'b1;
	data = S_AXI_RDATA;
	resp = S_AXI_RRESP;
	@(negedge S_AXI_ACLK);
	S_AXI_RREADY = 1'b0;
endtask

`endif

//--- sim/tb_gpu_registers.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gpu_registers;

	localparam int ADDR_W  = gpu_reg_pkg::DEF_ADDR_W;
	localparam int TIMEOUT = 32;   // cycles per wait
	localparam int DW      = gpu_reg_pkg::DATA_W;

	typedef logic [ADDR_W-1:0] addr_t;

	logic                    S_AXI_ACLK;
	logic                    S_AXI_ARESETN;
	addr_t                   S_AXI_AWADDR;
	logic                    S_AXI_AWVALID;
	logic                    S_AXI_AWREADY;
	gpu_reg_pkg::data_t      S_AXI_WDATA;
	gpu_reg_pkg::strb_t      S_AXI_WSTRB;
	logic                    S_AXI_WVALID;
	logic                    S_AXI_WREADY;
	gpu_reg_pkg::resp_t      S_AXI_BRESP;
	logic                    S_AXI_BVALID;
	logic                    S_AXI_BREADY;
	addr_t                   S_AXI_ARADDR;
	logic                    S_AXI_ARVALID;
	logic                    S_AXI_ARREADY;
	gpu_reg_pkg::data_t      S_AXI_RDATA;
	gpu_reg_pkg::resp_t      S_AXI_RRESP;
	logic                    S_AXI_RVALID;
	logic                    S_AXI_RREADY;
	gpu_reg_pkg::ctrl_bank_t ctrl_regs;
	gpu_reg_pkg::stat_bank_t stat_regs;

	gpu_reg_pkg::data_t model_ctrl [gpu_reg_pkg::NUM_CTRL];

	gpu_registers #(
		.ADDR_W (ADDR_W)
	) dut
	(
		.*,
		.o_ctrl_regs (ctrl_regs),
		.i_stat_regs (stat_regs)
	);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_data(input string name, input gpu_reg_pkg::data_t got,
		input gpu_reg_pkg::data_t exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_resp(input string name, input gpu_reg_pkg::resp_t got,
		input gpu_reg_pkg::resp_t exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bank(input string name, input gpu_reg_pkg::ctrl_bank_t got,
		input gpu_reg_pkg::ctrl_bank_t exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp)
			fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
	endtask

	`include "tb_axi_tasks.svh"

	// --------------------------------------------------
	// register model
	// --------------------------------------------------
	function automatic gpu_reg_pkg::data_t merge_bytes(input gpu_reg_pkg::data_t old_w,
		input gpu_reg_pkg::data_t new_w, input gpu_reg_pkg::strb_t strb);
		gpu_reg_pkg::data_t res;
		res = old_w;
		for (int b = 0; b < gpu_reg_pkg::STRB_W; b++)
			if (strb[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		return res;
	endfunction

	function automatic gpu_reg_pkg::ctrl_bank_t model_bank();
		gpu_reg_pkg::ctrl_bank_t bank;
		for (int i = 0; i < gpu_reg_pkg::NUM_CTRL; i++)
			bank[i*DW +: DW] = model_ctrl[i];
		return bank;
	endfunction

	function automatic gpu_reg_pkg::data_t expect_word(input gpu_reg_pkg::idx_t idx);
		gpu_reg_pkg::data_t w;
		w = model_ctrl[idx[3:0]];
		for (int i = 0; i < gpu_reg_pkg::NUM_STAT; i++)
			if (idx[4] && int'(idx[3:0]) == i)
				w = stat_regs[i*DW +: DW];
		return w;
	endfunction

	// index in bits 6..2, junk everywhere else
	function automatic addr_t make_addr(input gpu_reg_pkg::idx_t idx);
		addr_t a;
		a = addr_t'($urandom);
		a[gpu_reg_pkg::IDX_LSB +: gpu_reg_pkg::IDX_W] = idx;
		return a;
	endfunction

	task automatic new_status();
		for (int i = 0; i < gpu_reg_pkg::NUM_STAT; i++)
			stat_regs[i*DW +: DW] = $urandom;
	endtask

	task automatic commit_write(input gpu_reg_pkg::idx_t idx, input gpu_reg_pkg::data_t data,
		input gpu_reg_pkg::strb_t strb, input gpu_reg_pkg::resp_t resp);
		check_resp("S_AXI_BRESP", resp, gpu_reg_pkg::RESP_OKAY);
		if (!idx[4])
			model_ctrl[idx[3:0]] = merge_bytes(model_ctrl[idx[3:0]], data, strb);
		check_bank("o_ctrl_regs", ctrl_regs, model_bank());
	endtask

	// --------------------------------------------------
	// transactions
	// --------------------------------------------------
	task automatic do_write(input gpu_reg_pkg::idx_t idx, input gpu_reg_pkg::data_t data,
		input gpu_reg_pkg::strb_t strb, input int hold);
		int lat_a;
		int lat_b;
		gpu_reg_pkg::resp_t resp;
		raise_write(make_addr(idx), data, strb);
		wait_write_accept(lat_a);
		wait_bvalid(lat_b);
		check_latency("BVALID latency", lat_a + lat_b, 2);
		finish_b(hold, resp);
		commit_write(idx, data, strb, resp);
	endtask

	task automatic do_read(input gpu_reg_pkg::idx_t idx, input int hold);
		int lat_a;
		int lat_r;
		gpu_reg_pkg::data_t data;
		gpu_reg_pkg::resp_t resp;
		raise_read(make_addr(idx));
		wait_read_accept(lat_a);
		wait_rvalid(lat_r);
		check_latency("RVALID latency", lat_a + lat_r, 2);
		finish_r(hold, data, resp);
		check_data("S_AXI_RDATA", data, expect_word(idx));
		check_resp("S_AXI_RRESP", resp, gpu_reg_pkg::RESP_OKAY);
	endtask

	// second AR raised while the first R beat is stalled
	task automatic overlap_reads(input gpu_reg_pkg::idx_t first, input gpu_reg_pkg::idx_t second);
		int lat;
		gpu_reg_pkg::data_t data;
		gpu_reg_pkg::resp_t resp;
		raise_read(make_addr(first));
		wait_read_accept(lat);
		wait_rvalid(lat);
		raise_read(make_addr(second));
		finish_r(2 + $urandom_range(4, 0), data, resp);
		check_data("S_AXI_RDATA", data, expect_word(first));
		check_resp("S_AXI_RRESP", resp, gpu_reg_pkg::RESP_OKAY);
		wait_read_accept(lat);
		wait_rvalid(lat);
		finish_r($urandom_range(3, 0), data, resp);
		check_data("S_AXI_RDATA", data, expect_word(second));
		check_resp("S_AXI_RRESP", resp, gpu_reg_pkg::RESP_OKAY);
	endtask

	task automatic overlap_writes();
		gpu_reg_pkg::idx_t  idx [2];
		gpu_reg_pkg::data_t data [2];
		gpu_reg_pkg::strb_t strb [2];
		gpu_reg_pkg::resp_t resp;
		int lat;
		for (int k = 0; k < 2; k++)
		begin
			idx[k]  = gpu_reg_pkg::idx_t'($urandom_range(31, 0));
			data[k] = $urandom;
			strb[k] = gpu_reg_pkg::strb_t'($urandom_range(15, 0));
		end
		raise_write(make_addr(idx[0]), data[0], strb[0]);
		wait_write_accept(lat);
		wait_bvalid(lat);
		raise_write(make_addr(idx[1]), data[1], strb[1]);   // waits behind B
		finish_b(2 + $urandom_range(4, 0), resp);
		commit_write(idx[0], data[0], strb[0], resp);
		wait_write_accept(lat);
		wait_bvalid(lat);
		finish_b($urandom_range(3, 0), resp);
		commit_write(idx[1], data[1], strb[1], resp);
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial
	begin
		gpu_reg_pkg::idx_t idx;
		void'($urandom(61));
		S_AXI_ARESETN = 1'b0;
		S_AXI_AWADDR  = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA   = '0;
		S_AXI_WSTRB   = '0;
		S_AXI_WVALID  = 1'b0;
		S_AXI_BREADY  = 1'b0;
		S_AXI_ARADDR  = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY  = 1'b0;
		for (int i = 0; i < gpu_reg_pkg::NUM_CTRL; i++)
			model_ctrl[i] = '0;
		new_status();
		repeat (4) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;

		check_bank("o_ctrl_regs", ctrl_regs, '0);
		check_data("S_AXI_RDATA", S_AXI_RDATA, '0);
		check_flag("S_AXI_AWREADY", S_AXI_AWREADY, 1'b0);
		check_flag("S_AXI_WREADY", S_AXI_WREADY, 1'b0);
		check_flag("S_AXI_BVALID", S_AXI_BVALID, 1'b0);
		check_flag("S_AXI_ARREADY", S_AXI_ARREADY, 1'b0);
		check_flag("S_AXI_RVALID", S_AXI_RVALID, 1'b0);
		for (int i = 0; i < gpu_reg_pkg::NUM_CTRL; i++)
			do_read(gpu_reg_pkg::idx_t'(i), 0);

		// mixed control and status traffic, each write read back
		for (int n = 0; n < 200; n++)
		begin
			idx = gpu_reg_pkg::idx_t'($urandom_range(31, 0));
			if ($urandom_range(7, 0) == 0)
				new_status();
			do_write(idx, $urandom, gpu_reg_pkg::strb_t'($urandom_range(15, 0)),
				$urandom_range(5, 0));
			do_read(idx, $urandom_range(5, 0));
		end

		for (int i = 16; i < 32; i++)
			do_read(gpu_reg_pkg::idx_t'(i), $urandom_range(3, 0));

		repeat (20)
		begin
			overlap_reads(gpu_reg_pkg::idx_t'($urandom_range(31, 0)),
				gpu_reg_pkg::idx_t'($urandom_range(31, 0)));
			overlap_writes();
		end

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+sim
design/gpu_reg_pkg.sv
design/reg_write_if.sv
design/gpu_reg_write_channel.sv
design/gpu_reg_bank.sv
design/gpu_reg_read_channel.sv
design/gpu_registers.sv
sim/tb_gpu_registers.sv
